// File: rtl/l2_cache_pkg.sv
package l2_cache_pkg;

    localparam int unsigned addr_bits   = 16;
    localparam int unsigned offset_bits = 4;                 // 16-byte lines
    localparam int unsigned line_bits   = 8 << offset_bits;  // 128
    localparam int unsigned num_ways    = 8;
    localparam int unsigned way_bits    = 3;

    typedef logic [addr_bits-1:0] l2_word;
    typedef logic [line_bits-1:0] l2_cacheline;
    typedef logic [way_bits-1:0]  l2_way_idx;

    // tree pseudo-LRU of one set
    // bit 0 root, bit 1 ways 0-3, bit 4 ways 4-7
    // bit 3 pair 0/1, bit 2 pair 2/3, bit 5 pair 4/5, bit 6 pair 6/7
    typedef logic [num_ways-2:0] l2_lru_bits;

    typedef struct packed {
        logic hit;
        logic dirty;
    } l2_way_status;

    typedef l2_way_status [num_ways-1:0] l2_way_state;

    typedef struct packed {
        logic v_in;       // only set on a fill
        logic d_in;
        logic load_v;
        logic load_d;
        logic load_line;
    } l2_way_ctl;

    typedef struct packed {
        l2_way_ctl [num_ways-1:0] way;
        logic                     load_lru;
    } l2_ctl;

endpackage

// File: rtl/l2_cache_control.sv
module l2_cache_control
    import l2_cache_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        mem_read,
    input  logic        mem_write,
    input  l2_way_state way_state,
    input  l2_lru_bits  lru_bits,
    input  l2_way_idx   victim,
    input  logic        pmem_resp,
    output l2_ctl       ctl,
    output l2_lru_bits  lru_next,
    output l2_way_idx   line_sel,
    output logic        addr_from_victim,
    output logic        mem_resp,
    output logic        pmem_read,
    output logic        pmem_write
);

    typedef enum logic [2:0] {
        idle,
        fetch_line,
        write_back,
        recover,
        recover_2
    } state_t;

    state_t    state;
    state_t    next_state;
    logic      req;
    logic      hit;
    l2_way_idx hit_way;

    // point every tree bit on the way's path away from it
    function automatic l2_lru_bits lru_touch(input l2_lru_bits cur, input l2_way_idx w);
        l2_lru_bits nxt;
        nxt = cur;
        nxt[0] = ~w[2];
        if (w[2]) begin
            nxt[4] = ~w[1];
            if (w[1]) begin
                nxt[6] = ~w[0];
            end else begin
                nxt[5] = ~w[0];
            end
        end else begin
            nxt[1] = ~w[1];
            if (w[1]) begin
                nxt[2] = ~w[0];
            end else begin
                nxt[3] = ~w[0];
            end
        end
        return nxt;
    endfunction

    assign req = mem_read ^ mem_write;  // both high is no request

    always_comb begin
        hit = 1'b0;
        hit_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (way_state[w].hit) begin
                hit = 1'b1;
                hit_way = l2_way_idx'(w);
            end
        end
    end

    always_comb begin
        ctl = '0;
        lru_next = lru_bits;
        line_sel = victim;
        addr_from_victim = 1'b0;
        mem_resp = 1'b0;
        pmem_read = 1'b0;
        pmem_write = 1'b0;
        next_state = state;

        case (state)
            idle: begin
                if (req && hit) begin
                    mem_resp = 1'b1;
                    line_sel = hit_way;  // steers mem_rdata
                    lru_next = lru_touch(lru_bits, hit_way);
                    ctl.load_lru = 1'b1;
                    if (mem_write) begin
                        ctl.way[hit_way].d_in = 1'b1;
                        ctl.way[hit_way].load_d = 1'b1;
                        ctl.way[hit_way].load_line = 1'b1;
                    end
                    next_state = recover;
                end else if (req) begin
                    if (way_state[victim].dirty) begin
                        next_state = write_back;
                    end else begin
                        next_state = fetch_line;
                    end
                end
            end
            write_back: begin
                pmem_write = 1'b1;
                addr_from_victim = 1'b1;  // victim tag and its line
                if (pmem_resp) begin
                    next_state = fetch_line;
                end
            end
            fetch_line: begin
                pmem_read = 1'b1;
                if (pmem_resp) begin
                    ctl.way[victim].v_in = 1'b1;
                    ctl.way[victim].d_in = 1'b0;
                    ctl.way[victim].load_v = 1'b1;
                    ctl.way[victim].load_d = 1'b1;
                    ctl.way[victim].load_line = 1'b1;
                    next_state = idle;  // completes as a hit there
                end
            end
            recover: next_state = recover_2;
            recover_2: next_state = idle;
            default: next_state = idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

endmodule

// File: rtl/l2_cache_lru.sv
module l2_cache_lru
    import l2_cache_pkg::*;
#(
    parameter int unsigned set_bits = 3
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [set_bits-1:0] set_index,
    input  logic                load,
    input  l2_lru_bits          lru_next,
    output l2_lru_bits          lru_bits,
    output l2_way_idx           victim
);

    localparam int unsigned num_sets = 1 << set_bits;

    l2_lru_bits tree_q [num_sets];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < num_sets; s++) begin
                tree_q[s] <= '0;  // first victim is way 0
            end
        end else if (load) begin
            tree_q[set_index] <= lru_next;
        end
    end

    assign lru_bits = tree_q[set_index];

    // walk from the root down to a leaf
    always_comb begin
        if (!lru_bits[0]) begin
            if (!lru_bits[1]) begin
                victim = lru_bits[3] ? 3'd1 : 3'd0;
            end else begin
                victim = lru_bits[2] ? 3'd3 : 3'd2;
            end
        end else begin
            if (!lru_bits[4]) begin
                victim = lru_bits[5] ? 3'd5 : 3'd4;
            end else begin
                victim = lru_bits[6] ? 3'd7 : 3'd6;
            end
        end
    end

endmodule

// File: rtl/l2_cache_ways.sv
module l2_cache_ways
    import l2_cache_pkg::*;
#(
    parameter int unsigned set_bits = 3
) (
    input  logic        clk,
    input  logic        rst_n,
    input  l2_word      address,
    input  l2_cacheline wdata,
    input  l2_cacheline pmem_rdata,
    input  l2_ctl       ctl,
    input  l2_way_idx   line_sel,
    input  logic        addr_from_victim,
    output l2_way_state way_state,
    output l2_cacheline rdata,
    output l2_word      pmem_address,
    output l2_cacheline pmem_wdata
);

    localparam int unsigned num_sets = 1 << set_bits;
    localparam int unsigned tag_bits = addr_bits - offset_bits - set_bits;

    logic [num_ways-1:0] valid_q [num_sets];
    logic [num_ways-1:0] dirty_q [num_sets];
    logic [tag_bits-1:0] tag_q   [num_sets][num_ways];
    l2_cacheline         line_q  [num_sets][num_ways];

    logic [set_bits-1:0] set_index;
    logic [tag_bits-1:0] req_tag;
    l2_word              addr_sel;

    assign set_index = address[offset_bits +: set_bits];
    assign req_tag   = address[addr_bits-1 -: tag_bits];

    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            way_state[w].hit   = valid_q[set_index][w] && (tag_q[set_index][w] == req_tag);
            way_state[w].dirty = valid_q[set_index][w] && dirty_q[set_index][w];
        end
    end

    assign rdata = line_q[set_index][line_sel];

    // victim line address or line-aligned request
    assign addr_sel = addr_from_victim ?
        {tag_q[set_index][line_sel], set_index, {offset_bits{1'b0}}} :
        {address[addr_bits-1:offset_bits], {offset_bits{1'b0}}};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < num_sets; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else begin
            for (int w = 0; w < num_ways; w++) begin
                if (ctl.way[w].load_v) begin
                    valid_q[set_index][w] <= ctl.way[w].v_in;
                end
                if (ctl.way[w].load_d) begin
                    dirty_q[set_index][w] <= ctl.way[w].d_in;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < num_ways; w++) begin
            if (ctl.way[w].load_line) begin
                tag_q[set_index][w]  <= req_tag;
                line_q[set_index][w] <= ctl.way[w].v_in ? pmem_rdata : wdata;  // fill or write hit
            end
        end
        pmem_address <= addr_sel;
        pmem_wdata   <= line_q[set_index][line_sel];
    end

endmodule

// File: rtl/l2_cache.sv
module l2_cache
    import l2_cache_pkg::*;
#(
    parameter int unsigned set_bits = 3
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        mem_read,
    input  logic        mem_write,
    input  l2_word      mem_address,
    input  l2_cacheline mem_wdata,
    output l2_cacheline mem_rdata,
    output logic        mem_resp,
    output logic        pmem_read,
    output logic        pmem_write,
    output l2_word      pmem_address,
    output l2_cacheline pmem_wdata,
    input  l2_cacheline pmem_rdata,
    input  logic        pmem_resp
);

    l2_way_state way_state;
    l2_ctl       ctl;
    l2_lru_bits  lru_bits;
    l2_lru_bits  lru_next;
    l2_way_idx   victim;
    l2_way_idx   line_sel;
    logic        addr_from_victim;

    l2_cache_control control_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .mem_read         (mem_read),
        .mem_write        (mem_write),
        .way_state        (way_state),
        .lru_bits         (lru_bits),
        .victim           (victim),
        .pmem_resp        (pmem_resp),
        .ctl              (ctl),
        .lru_next         (lru_next),
        .line_sel         (line_sel),
        .addr_from_victim (addr_from_victim),
        .mem_resp         (mem_resp),
        .pmem_read        (pmem_read),
        .pmem_write       (pmem_write)
    );

    l2_cache_lru #(
        .set_bits (set_bits)
    ) lru_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .set_index (mem_address[offset_bits +: set_bits]),
        .load      (ctl.load_lru),
        .lru_next  (lru_next),
        .lru_bits  (lru_bits),
        .victim    (victim)
    );

    l2_cache_ways #(
        .set_bits (set_bits)
    ) ways_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .address          (mem_address),
        .wdata            (mem_wdata),
        .pmem_rdata       (pmem_rdata),
        .ctl              (ctl),
        .line_sel         (line_sel),
        .addr_from_victim (addr_from_victim),
        .way_state        (way_state),
        .rdata            (mem_rdata),
        .pmem_address     (pmem_address),
        .pmem_wdata       (pmem_wdata)
    );

endmodule

// File: verification/l2_cache_tb.sv
module l2_cache_tb;
    import l2_cache_pkg::*;

    localparam int unsigned set_bits = 3;
    localparam int unsigned tag_bits = addr_bits - offset_bits - set_bits;
    localparam int fixed_requests = 27;
    localparam int random_requests = 200;
    localparam int cycle_limit = (fixed_requests + random_requests) * 20;

    typedef struct packed {
        l2_word      addr;
        l2_cacheline data;
    } line_xfer;

    logic        clk;
    logic        rst_n;
    logic        mem_read;
    logic        mem_write;
    l2_word      mem_address;
    l2_cacheline mem_wdata;
    l2_cacheline mem_rdata;
    logic        mem_resp;
    logic        pmem_read;
    logic        pmem_write;
    l2_word      pmem_address;
    l2_cacheline pmem_wdata;
    l2_cacheline pmem_rdata;
    logic        pmem_resp;

    int          seed = 32'he1f91a95;
    int          mem_seed = 32'he1f91a95;
    string       test_name;
    int          errors;
    int          err_mark;
    int          tests_passed;
    int          tests_failed;
    int          wb_seen;
    int          fill_seen;
    l2_word      last_fill_addr;
    bit          last_miss;
    bit          last_wb;
    line_xfer    last_victim;
    line_xfer    wb_q [$];

    // reference cache state
    bit                  ref_valid [1 << set_bits][num_ways];
    bit                  ref_dirty [1 << set_bits][num_ways];
    logic [tag_bits-1:0] ref_tag   [1 << set_bits][num_ways];
    l2_cacheline         ref_line  [1 << set_bits][num_ways];
    l2_lru_bits          ref_tree  [1 << set_bits] = '{default: '0};
    l2_cacheline         flat_mem  [l2_word];  // what the requester should see
    l2_cacheline         phys_mem  [l2_word];  // backing store behind the DUT

    l2_cache #(.set_bits(set_bits)) l2_cache_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic l2_cacheline init_line(input l2_word addr);
        return {8{addr}} ^ {4{32'h9e3779b9}};
    endfunction

    function automatic l2_cacheline flat_read(input l2_word line_addr);
        return flat_mem.exists(line_addr) ? flat_mem[line_addr] : init_line(line_addr);
    endfunction

    function automatic l2_word make_addr(input int tag, input int set_idx);
        return l2_word'((tag << (offset_bits + set_bits)) | (set_idx << offset_bits));
    endfunction

    // tree bit on the path to a way where depth 0 is the root
    function automatic int path_node(input int way, input int depth);
        if (depth == 0) return 0;
        if (depth == 1) return way[2] ? 4 : 1;
        return way[2] ? (way[1] ? 6 : 5) : (way[1] ? 2 : 3);
    endfunction

    function automatic int tree_victim(input l2_lru_bits tree);
        bit all_point;
        for (int w = 0; w < num_ways; w++) begin
            all_point = 1'b1;
            for (int d = 0; d < 3; d++) begin
                if (tree[path_node(w, d)] != w[2-d]) all_point = 1'b0;
            end
            if (all_point) return w;
        end
        return 0;
    endfunction

    function automatic l2_lru_bits tree_touch(input l2_lru_bits tree, input int way);
        for (int d = 0; d < 3; d++) begin
            tree[path_node(way, d)] = ~way[2-d];  // point away from the way
        end
        return tree;
    endfunction

    function automatic l2_cacheline ref_access(input bit is_write, input l2_word addr,
                                               input l2_cacheline wdata, output bit miss,
                                               output bit wb, output line_xfer victim);
        logic [set_bits-1:0] set_idx;
        logic [tag_bits-1:0] tag;
        l2_word              line_addr;
        int                  way;
        set_idx = addr[offset_bits +: set_bits];
        tag = addr[addr_bits-1 -: tag_bits];
        line_addr = {addr[addr_bits-1:offset_bits], {offset_bits{1'b0}}};
        miss = 1'b1;
        wb = 1'b0;
        way = 0;
        victim = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (ref_valid[set_idx][w] && ref_tag[set_idx][w] == tag) begin
                miss = 1'b0;
                way = w;
            end
        end
        if (miss) begin
            way = tree_victim(ref_tree[set_idx]);
            victim.addr = {ref_tag[set_idx][way], set_idx, {offset_bits{1'b0}}};
            victim.data = ref_line[set_idx][way];
            wb = ref_valid[set_idx][way] && ref_dirty[set_idx][way];
            ref_valid[set_idx][way] = 1'b1;
            ref_dirty[set_idx][way] = 1'b0;
            ref_tag[set_idx][way] = tag;
            ref_line[set_idx][way] = flat_read(line_addr);
        end
        ref_tree[set_idx] = tree_touch(ref_tree[set_idx], way);
        if (is_write) begin
            ref_line[set_idx][way] = wdata;
            ref_dirty[set_idx][way] = 1'b1;
            flat_mem[line_addr] = wdata;
        end
        return flat_read(line_addr);
    endfunction

    task automatic flag_error(input string what);
        errors++;
        $display("%s: %s", test_name, what);
    endtask

    task automatic check_line(input l2_cacheline expected, input l2_cacheline actual);
        if (actual !== expected) begin
            errors++;
            $display("Fail %s expected %h actual %h", test_name, expected, actual);
        end
    endtask

    task automatic check_addr(input l2_word expected, input l2_word actual);
        if (actual !== expected) begin
            errors++;
            $display("Fail %s expected %h actual %h", test_name, expected, actual);
        end
    endtask

    task automatic test_start(input string name);
        test_name = name;
        err_mark = errors;
    endtask

    task automatic test_end();
        if (errors == err_mark) begin
            tests_passed++;
            $display("test %s passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", test_name, errors - err_mark);
        end
    endtask

    task automatic do_access(input bit is_write, input l2_word addr, input l2_cacheline wdata);
        l2_cacheline expected;
        l2_cacheline got;
        int          wb_before;
        int          fill_before;
        expected = ref_access(is_write, addr, wdata, last_miss, last_wb, last_victim);
        if (last_wb) wb_q.push_back(last_victim);
        wb_before = wb_seen;
        fill_before = fill_seen;
        mem_read = !is_write;
        mem_write = is_write;
        mem_address = addr;
        mem_wdata = wdata;
        do @(posedge clk); while (!mem_resp);
        got = mem_rdata;
        @(negedge clk);
        mem_read = 1'b0;
        mem_write = 1'b0;
        if (!is_write) check_line(expected, got);
        if (wb_seen - wb_before != int'(last_wb)) flag_error("write-back count is wrong");
        if (fill_seen - fill_before != int'(last_miss)) flag_error("line fill count is wrong");
    endtask

    // slow memory answering each strobe in 2 to 5 cycles
    initial begin : memory_model
        int wait_cycles;
        pmem_resp = 1'b0;
        pmem_rdata = '0;
        forever begin
            @(negedge clk);
            pmem_resp = 1'b0;
            if (pmem_read || pmem_write) begin
                wait_cycles = 2 + {$random(mem_seed)} % 4;
                repeat (wait_cycles) @(negedge clk);
                if (pmem_write) begin
                    phys_mem[pmem_address] = pmem_wdata;
                end else begin
                    pmem_rdata = phys_mem.exists(pmem_address) ? phys_mem[pmem_address]
                                                               : init_line(pmem_address);
                end
                pmem_resp = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        if (pmem_resp && pmem_write) begin
            wb_seen++;
            if (wb_q.size() == 0) begin
                flag_error($sformatf("write-back to %h was not expected", pmem_address));
            end else begin
                check_addr(wb_q[0].addr, pmem_address);
                check_line(wb_q[0].data, pmem_wdata);
                void'(wb_q.pop_front());
            end
        end
        if (pmem_resp && pmem_read) begin
            fill_seen++;
            last_fill_addr = pmem_address;
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > cycle_limit) begin
                $display("timeout after %0d cycles, the DUT stopped answering", cycles);
                $display("Simulation FAILED");
                $finish;
            end
        end
    end

    initial begin
        l2_word evicted;
        int     r_tag;
        int     r_set;
        int     wb_mark;
        rst_n = 1'b0;
        mem_read = 1'b0;
        mem_write = 1'b0;
        mem_address = '0;
        mem_wdata = '0;
        errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        test_start("reset_state");
        if (mem_resp !== 1'b0 || pmem_read !== 1'b0 || pmem_write !== 1'b0) begin
            flag_error("response or memory strobes not low after reset");
        end
        do_access(1'b0, make_addr(1, 0), '0);
        test_end();

        test_start("read_hit");
        do_access(1'b0, make_addr(1, 0), '0);
        test_end();

        test_start("write_hit");
        do_access(1'b1, make_addr(1, 0), {4{32'hcafef00d}});
        do_access(1'b0, make_addr(1, 0), '0);
        test_end();

        test_start("victim_choice");
        for (int t = 0; t < 8; t++) do_access(1'b0, make_addr(t, 1), '0);
        do_access(1'b0, make_addr(2, 1), '0);
        do_access(1'b0, make_addr(5, 1), '0);
        do_access(1'b0, make_addr(0, 1), '0);
        do_access(1'b0, make_addr(8, 1), '0);
        evicted = last_victim.addr;
        do_access(1'b0, evicted, '0);  // must refill from memory
        check_addr(evicted, last_fill_addr);
        test_end();

        test_start("dirty_eviction");
        for (int t = 0; t < 8; t++) do_access(1'b1, make_addr(t, 2), {4{32'hd1a70000 + t}});
        wb_mark = wb_seen;
        do_access(1'b0, make_addr(9, 2), '0);
        if (wb_seen - wb_mark != 1) flag_error("dirty victim did not give exactly one write-back");
        test_end();

        test_start("clean_eviction");
        do_access(1'b0, make_addr(9, 1), '0);
        test_end();

        test_start("random_traffic");
        for (int i = 0; i < random_requests; i++) begin
            r_tag = {$random(seed)} % 16;
            r_set = {$random(seed)} % 4;
            do_access(bit'($random(seed) & 1),
                      l2_word'(make_addr(r_tag, r_set) | ({$random(seed)} % 16)),
                      {$random(seed), $random(seed), $random(seed), $random(seed)});
        end
        if (wb_q.size() != 0) flag_error("an expected write-back never reached memory");
        test_end();

        $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: sources.f
rtl/l2_cache_pkg.sv
rtl/l2_cache_control.sv
rtl/l2_cache_lru.sv
rtl/l2_cache_ways.sv
rtl/l2_cache.sv
verification/l2_cache_tb.sv

// File: Bender.yml
package:
  name: l2_cache

sources:
  - rtl/l2_cache_pkg.sv
  - rtl/l2_cache_control.sv
  - rtl/l2_cache_lru.sv
  - rtl/l2_cache_ways.sv
  - rtl/l2_cache.sv
  - target: test
    files:
      - verification/l2_cache_tb.sv
